// ==== include/tnn_macros.svh ====
`ifndef TNN_MACROS_SVH
`define TNN_MACROS_SVH

// Vector geometry
`define TNN_LANES 4         // Lanes per vector
`define TNN_LANE_W 8        // Signed lane width
`define TNN_TRIT_W 2        // One weight trit
`define TNN_VEC_W 32        // Vector or packed 4x4 weight matrix

// Storage pieces
`define TNN_PIECE_W 16      // Width of one stored half
`define TNN_PIECES 2        // Halves per entry, low half first

// Instruction word
`define TNN_OP_W 8          // Opcode in [7:5], operand in [4:0]
`define TNN_OPND_W 5        // Operand field

// Memory depths in entries
`define TNN_OP_ADDRS 32
`define TNN_DATA_ADDRS 32
`define TNN_WEIGHT_ADDRS 8
`define TNN_HEAP_ADDRS 8

// Host load address, covers 64 data pieces
`define TNN_LOAD_ADDR_W 6

`endif

// ==== verification/tnn_tb.sv ====
`timescale 1ns/1ps
`include "tnn_macros.svh"

module tnn_tb;
  import tnn_pkg::*;

  // Six runs of up to 12 instructions at about 10 cycles each, plus host loads, with margin
  localparam int CYCLE_LIMIT = 4000;
  localparam int SEL_OP      = 0;
  localparam int SEL_DATA    = 1;
  localparam int SEL_WEIGHT  = 2;

  logic                         clk_100mhz;
  logic                         rst_n;
  logic                         start;
  logic                         op_load_we, data_load_we, weight_load_we;
  logic [`TNN_LOAD_ADDR_W-1:0]  load_addr;
  piece_t                       load_data;
  logic                         busy, done, inference_valid;
  vec_t                         inference_out;

  logic [31:0]  rng_state = 32'd87000;     // Xorshift state
  vec_t         expected_q[$];             // Outputs still owed by the DUT
  logic [7:0]   prog_q[$];                 // Program being assembled
  vec_t         exp_vec;
  vec_t         last_out;                  // Most recent checked output
  int           cycle_count = 0;
  int           error_count = 0;
  int           test_errors_at_start = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;

  tnn_top dut0 (
    .clk_100mhz, .rst_n, .start,
    .op_load_we, .data_load_we, .weight_load_we,
    .load_addr, .load_data,
    .busy, .done, .inference_valid, .inference_out
  );

  always #10 clk_100mhz = ~clk_100mhz;    // 20 ns period

  always @(posedge clk_100mhz) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  // Status rules from the host interface
  a_done_idle: assert property (@(posedge clk_100mhz) disable iff (!rst_n) !(busy && done))
    else begin
      error_count++;
      $display("FAILED at %0t: busy and done high together", $time);
    end
  a_done_on_fall: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
                                   $fell(busy) |-> done)
    else begin
      error_count++;
      $display("FAILED at %0t: done did not rise as busy fell", $time);
    end
  a_valid_busy: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
                                 inference_valid |-> busy)
    else begin
      error_count++;
      $display("FAILED at %0t: inference_valid outside a run", $time);
    end

  // Each valid pulse consumes one expected vector, in order
  always @(posedge clk_100mhz) begin
    if (rst_n && inference_valid) begin
      if (expected_q.size() == 0) begin
        error_count++;
        $display("Unexpected inference output %h at %0t", inference_out, $time);
      end else begin
        exp_vec  = expected_q.pop_front();
        last_out = inference_out;
        a_output: assert (inference_out == exp_vec)
          else begin
            error_count++;
            $display("FAILED at %0t: inference_out %h, expected %h",
                     $time, inference_out, exp_vec);
          end
      end
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Reference model, signed sums reduced to 8 bits
  function automatic vec_t ref_matvec(input vec_t w, input vec_t x);
    vec_t        y;
    int          sum;
    int          weight;
    logic [1:0]  code;
    y = '0;
    for (int i = 0; i < 4; i++) begin
      sum = 0;
      for (int j = 0; j < 4; j++) begin
        code   = w[2*(4*i+j) +: 2];
        weight = (code == 2'b01) ? 1 : ((code == 2'b11) ? -1 : 0);
        sum    = sum + weight * int'($signed(x[8*j +: 8]));
      end
      y[8*i +: 8] = sum[7:0];                      // Modulo 256
    end
    return y;
  endfunction

  function automatic vec_t ref_relu(input vec_t x);
    vec_t y;
    for (int i = 0; i < 4; i++) begin
      y[8*i +: 8] = ($signed(x[8*i +: 8]) < 0) ? 8'd0 : x[8*i +: 8];
    end
    return y;
  endfunction

  function automatic logic [7:0] encode(input op_e op, input int opnd);
    return {op, opnd[4:0]};
  endfunction

  task automatic write_piece(input int sel, input int addr, input piece_t value);
    @(posedge clk_100mhz);
    op_load_we     <= (sel == SEL_OP);
    data_load_we   <= (sel == SEL_DATA);
    weight_load_we <= (sel == SEL_WEIGHT);
    load_addr      <= addr[`TNN_LOAD_ADDR_W-1:0];
    load_data      <= value;
    @(posedge clk_100mhz);
    op_load_we     <= 1'b0;
    data_load_we   <= 1'b0;
    weight_load_we <= 1'b0;
  endtask

  task automatic load_vec(input int sel, input int entry, input vec_t value);
    write_piece(sel, 2*entry, value[15:0]);        // Piece 0 is the low half
    write_piece(sel, 2*entry + 1, value[31:16]);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_q.size(); i++) begin
      write_piece(SEL_OP, i, {8'd0, prog_q[i]});
    end
    prog_q.delete();
  endtask

  task automatic run_program();
    @(posedge clk_100mhz);
    start <= 1'b1;
    @(posedge clk_100mhz);
    start <= 1'b0;
    @(negedge clk_100mhz);
    a_started: assert (busy && !done)
      else begin
        error_count++;
        $display("FAILED at %0t: busy %b done %b after start", $time, busy, done);
      end
    do @(negedge clk_100mhz); while (!done);       // Timeout counter guards this
    @(negedge clk_100mhz);
    if (expected_q.size() != 0) begin
      error_count++;
      $display("Run ended with %0d expected outputs missing", expected_q.size());
      expected_q.delete();
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (error_count == test_errors_at_start) begin
      tests_passed++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", num, name, error_count - test_errors_at_start);
    end
    test_errors_at_start = error_count;
  endtask

  initial begin
    vec_t x, y, w, mv;
    clk_100mhz = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    op_load_we = 1'b0;
    data_load_we = 1'b0;
    weight_load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (2) @(posedge clk_100mhz);
    rst_n <= 1'b1;

    @(negedge clk_100mhz);
    a_reset: assert (!busy && !done && !inference_valid && inference_out == '0)
      else begin
        error_count++;
        $display("FAILED at %0t: outputs not cleared by reset", $time);
      end
    finish_test(1, "reset_state");

    x = next_rand();
    load_vec(SEL_DATA, 5, x);
    prog_q = '{encode(OP_LOAD_X, 5), encode(OP_OUTPUT, 0), encode(OP_HALT, 0)};
    load_program();
    expected_q.push_back(x);
    run_program();
    finish_test(2, "load_output");

    x = next_rand();
    w = next_rand();                               // Any 2-bit code is a valid trit
    load_vec(SEL_DATA, 1, x);
    load_vec(SEL_WEIGHT, 2, w);
    prog_q = '{encode(OP_LOAD_X, 1), encode(OP_MATVEC, 2), encode(OP_OUTPUT, 0),
               encode(OP_HALT, 0)};
    load_program();
    expected_q.push_back(ref_matvec(w, x));
    run_program();
    finish_test(3, "matvec");

    x = next_rand();
    w = next_rand();
    load_vec(SEL_DATA, 1, x);
    load_vec(SEL_WEIGHT, 2, w);
    mv = ref_matvec(w, x);
    prog_q = '{encode(OP_LOAD_X, 1), encode(OP_MATVEC, 2), encode(OP_OUTPUT, 0),
               encode(OP_RELU, 0), encode(OP_OUTPUT, 0), encode(OP_HALT, 0)};
    load_program();
    expected_q.push_back(mv);
    expected_q.push_back(ref_relu(mv));
    run_program();
    a_relu_lanes: assert (!last_out[7] && !last_out[15] && !last_out[23] && !last_out[31])
      else begin
        error_count++;
        $display("FAILED at %0t: negative lane after ReLU in %h", $time, last_out);
      end
    finish_test(4, "matvec_relu");

    x = next_rand();
    y = next_rand();
    load_vec(SEL_DATA, 3, x);
    load_vec(SEL_DATA, 4, y);
    prog_q = '{encode(OP_LOAD_X, 3), encode(OP_STORE_HEAP, 6), encode(OP_LOAD_X, 4),
               encode(OP_OUTPUT, 0), encode(OP_LOAD_HEAP, 6), encode(OP_OUTPUT, 0),
               encode(OP_NOP, 0), encode(OP_HALT, 0)};
    load_program();
    expected_q.push_back(y);
    expected_q.push_back(x);
    run_program();
    finish_test(5, "heap_round_trip");

    x = next_rand();                               // Restart from the halted state
    w = next_rand();
    load_vec(SEL_DATA, 7, x);
    load_vec(SEL_WEIGHT, 5, w);
    mv = ref_matvec(w, x);
    prog_q = '{encode(OP_LOAD_X, 7), encode(OP_MATVEC, 5), encode(OP_STORE_HEAP, 2),
               encode(OP_RELU, 0), encode(OP_OUTPUT, 0), encode(OP_LOAD_HEAP, 2),
               encode(OP_OUTPUT, 0), encode(OP_HALT, 0)};
    load_program();
    expected_q.push_back(ref_relu(mv));
    expected_q.push_back(mv);
    run_program();
    finish_test(6, "second_start");

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verilog/cpu_control.sv ====
`timescale 1ns/1ps
`include "tnn_macros.svh"

module cpu_control (
  input  logic                                  clk_100mhz,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  logic [`TNN_OP_W-1:0]                  instr,
  input  logic                                  instr_valid,
  input  logic                                  data_done,
  input  tnn_pkg::vec_t                         data_vec,
  input  logic                                  weight_done,
  input  tnn_pkg::vec_t                         weight_vec,
  input  logic                                  heap_rd_done,
  input  logic                                  heap_wr_done,
  input  tnn_pkg::vec_t                         heap_vec,
  input  tnn_pkg::vec_t                         acc,
  output logic                                  fetch_req,
  output logic [$clog2(`TNN_OP_ADDRS)-1:0]      pc,
  output logic                                  data_rd_req,
  output logic [$clog2(`TNN_DATA_ADDRS)-1:0]    data_addr,
  output logic                                  weight_rd_req,
  output logic [$clog2(`TNN_WEIGHT_ADDRS)-1:0]  weight_addr,
  output logic                                  heap_rd_req,
  output logic                                  heap_wr_req,
  output logic [$clog2(`TNN_HEAP_ADDRS)-1:0]    heap_addr,
  output logic                                  alu_go,
  output tnn_pkg::alu_op_e                      alu_op,
  output tnn_pkg::vec_t                         alu_operand,
  output logic                                  busy,
  output logic                                  done,
  output logic                                  inference_valid,
  output tnn_pkg::vec_t                         inference_out
);
  import tnn_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_DECODE, S_WAIT_MEM, S_EXECUTE, S_HALTED
  } state_e;

  state_e                  state;
  op_e                     op_q;    // Decoded opcode of the current instruction
  logic [`TNN_OPND_W-1:0]  opnd_q;  // Operand field

  // Memory addresses come straight from the operand, small memories use low bits
  assign data_addr   = opnd_q;
  assign weight_addr = opnd_q[$clog2(`TNN_WEIGHT_ADDRS)-1:0];
  assign heap_addr   = opnd_q[$clog2(`TNN_HEAP_ADDRS)-1:0];

  always_comb begin
    case (op_q)
      OP_MATVEC: alu_op = ALU_MATVEC;
      OP_RELU:   alu_op = ALU_RELU;
      default:   alu_op = ALU_LOAD;    // Both load opcodes
    endcase
  end

  // Reader outputs hold until the next request, so a plain mux is enough
  always_comb begin
    case (op_q)
      OP_MATVEC:    alu_operand = weight_vec;
      OP_LOAD_HEAP: alu_operand = heap_vec;
      default:      alu_operand = data_vec;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (state == S_FETCH && instr_valid) begin
      op_q   <= op_e'(instr[`TNN_OP_W-1:`TNN_OPND_W]);
      opnd_q <= instr[`TNN_OPND_W-1:0];
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      state           <= S_IDLE;
      pc              <= '0;
      busy            <= 1'b0;
      done            <= 1'b0;
      fetch_req       <= 1'b0;
      data_rd_req     <= 1'b0;
      weight_rd_req   <= 1'b0;
      heap_rd_req     <= 1'b0;
      heap_wr_req     <= 1'b0;
      alu_go          <= 1'b0;
      inference_valid <= 1'b0;
      inference_out   <= '0;
    end else begin
      fetch_req       <= 1'b0;  // All requests are single-cycle pulses
      data_rd_req     <= 1'b0;
      weight_rd_req   <= 1'b0;
      heap_rd_req     <= 1'b0;
      heap_wr_req     <= 1'b0;
      alu_go          <= 1'b0;
      inference_valid <= 1'b0;
      case (state)
        S_IDLE, S_HALTED: begin
          if (start) begin
            busy      <= 1'b1;
            done      <= 1'b0;   // Cleared by the new run
            pc        <= '0;
            fetch_req <= 1'b1;
            state     <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (instr_valid) begin
            pc    <= pc + 1'b1;  // Wraps at program depth
            state <= S_DECODE;
          end
        end
        S_DECODE: begin
          case (op_q)
            OP_LOAD_X: begin
              data_rd_req <= 1'b1;
              state       <= S_WAIT_MEM;
            end
            OP_LOAD_HEAP: begin
              heap_rd_req <= 1'b1;
              state       <= S_WAIT_MEM;
            end
            OP_MATVEC: begin
              weight_rd_req <= 1'b1;  // Weights arrive as the ALU operand
              state         <= S_WAIT_MEM;
            end
            OP_STORE_HEAP: begin
              heap_wr_req <= 1'b1;
              state       <= S_WAIT_MEM;
            end
            OP_RELU: begin
              alu_go <= 1'b1;
              state  <= S_EXECUTE;
            end
            OP_OUTPUT: begin
              inference_out   <= acc;
              inference_valid <= 1'b1;
              fetch_req       <= 1'b1;
              state           <= S_FETCH;
            end
            OP_HALT: begin
              busy  <= 1'b0;
              done  <= 1'b1;           // Holds until next start
              state <= S_HALTED;
            end
            default: begin             // NOP
              fetch_req <= 1'b1;
              state     <= S_FETCH;
            end
          endcase
        end
        S_WAIT_MEM: begin
          if (data_done || weight_done || heap_rd_done) begin
            alu_go <= 1'b1;
            state  <= S_EXECUTE;
          end else if (heap_wr_done) begin
            fetch_req <= 1'b1;         // Store needs no ALU step
            state     <= S_FETCH;
          end
        end
        S_EXECUTE: begin
          fetch_req <= 1'b1;           // acc took the update on the last edge
          state     <= S_FETCH;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/heap_store.sv ====
`timescale 1ns/1ps
`include "tnn_macros.svh"

module heap_store (
  input  logic                               clk_100mhz,
  input  logic                               rst_n,
  input  logic                               wr_req,     // Store wr_vec at heap_addr
  input  logic                               rd_req,     // Fetch entry at heap_addr
  input  logic [$clog2(`TNN_HEAP_ADDRS)-1:0] heap_addr,
  input  tnn_pkg::vec_t                      wr_vec,
  output tnn_pkg::vec_t                      rd_vec,
  output logic                               wr_done,    // 2 cycles after wr_req
  output logic                               rd_done     // 3 cycles after rd_req
);
  import tnn_pkg::*;

  localparam int HAW = $clog2(`TNN_HEAP_ADDRS);
  localparam int PAD = `TNN_LOAD_ADDR_W - HAW - 1;

  logic [HAW-1:0]               addr_q;
  piece_t                       hi_q;       // High half waits one cycle
  logic                         wr_step;    // Second write cycle
  logic                         mem_we;
  logic [`TNN_LOAD_ADDR_W-1:0]  mem_addr;
  piece_t                       mem_data;

  // Piece 0 on the request cycle, piece 1 on the next
  assign mem_we   = wr_req || wr_step;
  assign mem_addr = wr_req ? {{PAD{1'b0}}, heap_addr, 1'b0}
                           : {{PAD{1'b0}}, addr_q, 1'b1};
  assign mem_data = wr_req ? wr_vec[`TNN_PIECE_W-1:0] : hi_q;

  always_ff @(posedge clk_100mhz) begin
    if (wr_req) begin
      addr_q <= heap_addr;
      hi_q   <= wr_vec[`TNN_VEC_W-1:`TNN_PIECE_W];
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      wr_step <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      wr_step <= wr_req;
      wr_done <= wr_step;  // Raised with the last piece written
    end
  end

  // Storage and two-step read share the reader block
  vector_reader #(.ADDRS(`TNN_HEAP_ADDRS)) heap_reader0 (
    .clk_100mhz,
    .rst_n,
    .load_we   (mem_we),
    .load_addr (mem_addr),
    .load_data (mem_data),
    .rd_req,
    .rd_addr   (heap_addr),
    .rd_vec,
    .rd_done
  );

endmodule

// ==== verilog/instruction_fetch.sv ====
`timescale 1ns/1ps
`include "tnn_macros.svh"

module instruction_fetch (
  input  logic                              clk_100mhz,
  input  logic                              rst_n,
  input  logic                              op_load_we,  // Host write strobe
  input  logic [`TNN_LOAD_ADDR_W-1:0]       load_addr,   // Instruction index, one per entry
  input  tnn_pkg::piece_t                   load_data,   // Low byte holds the instruction
  input  logic                              fetch_req,
  input  logic [$clog2(`TNN_OP_ADDRS)-1:0]  pc,
  output logic [`TNN_OP_W-1:0]              instr,       // Holds until next fetch
  output logic                              instr_valid  // One cycle after fetch_req
);

  localparam int PCW = $clog2(`TNN_OP_ADDRS);

  logic [`TNN_OP_W-1:0] prog_mem [`TNN_OP_ADDRS];

  always_ff @(posedge clk_100mhz) begin
    if (op_load_we) begin
      prog_mem[load_addr[PCW-1:0]] <= load_data[`TNN_OP_W-1:0];
    end
  end

  // Registered read, only on request
  always_ff @(posedge clk_100mhz) begin
    if (fetch_req) begin
      instr <= prog_mem[pc];
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= fetch_req;
    end
  end

endmodule

// ==== verilog/tnn_pkg.sv ====
`include "tnn_macros.svh"

package tnn_pkg;

  // Lane i at [8i+7:8i], trit (i,j) at [2(4i+j)+1:2(4i+j)]
  typedef logic [`TNN_VEC_W-1:0] vec_t;

  // One stored half of an entry
  typedef logic [`TNN_PIECE_W-1:0] piece_t;

  // Opcodes, held in instr[7:5]
  typedef enum logic [2:0] {
    OP_NOP        = 3'd0,  // Do nothing
    OP_LOAD_X     = 3'd1,  // acc <= data[opnd]
    OP_LOAD_HEAP  = 3'd2,  // acc <= heap[opnd]
    OP_MATVEC     = 3'd3,  // acc <= W[opnd] * acc
    OP_RELU       = 3'd4,  // Clamp negative lanes
    OP_STORE_HEAP = 3'd5,  // heap[opnd] <= acc
    OP_OUTPUT     = 3'd6,  // Publish acc
    OP_HALT       = 3'd7   // End of program
  } op_e;

  // Accumulator commands
  typedef enum logic [1:0] {
    ALU_LOAD   = 2'd0,  // Copy operand
    ALU_MATVEC = 2'd1,  // Ternary matrix times acc
    ALU_RELU   = 2'd2   // Zero negative lanes
  } alu_op_e;

endpackage

// ==== verilog/tnn_top.sv ====
`timescale 1ns/1ps
`include "tnn_macros.svh"

module tnn_top (
  input  logic                         clk_100mhz,
  input  logic                         rst_n,
  input  logic                         start,           // Run pulse, only while idle
  input  logic                         op_load_we,      // Program memory strobe
  input  logic                         data_load_we,    // Data memory strobe
  input  logic                         weight_load_we,  // Weight memory strobe
  input  logic [`TNN_LOAD_ADDR_W-1:0]  load_addr,       // Entry*2 + piece
  input  tnn_pkg::piece_t              load_data,
  output logic                         busy,
  output logic                         done,
  output logic                         inference_valid,
  output tnn_pkg::vec_t                inference_out
);
  import tnn_pkg::*;

  logic                                  fetch_req;
  logic [$clog2(`TNN_OP_ADDRS)-1:0]      pc;
  logic [`TNN_OP_W-1:0]                  instr;
  logic                                  instr_valid;
  logic                                  data_rd_req, data_done;
  logic [$clog2(`TNN_DATA_ADDRS)-1:0]    data_addr;
  vec_t                                  data_vec;
  logic                                  weight_rd_req, weight_done;
  logic [$clog2(`TNN_WEIGHT_ADDRS)-1:0]  weight_addr;
  vec_t                                  weight_vec;
  logic                                  heap_rd_req, heap_wr_req;
  logic                                  heap_rd_done, heap_wr_done;
  logic [$clog2(`TNN_HEAP_ADDRS)-1:0]    heap_addr;
  vec_t                                  heap_vec;
  logic                                  alu_go;
  alu_op_e                               alu_op;
  vec_t                                  alu_operand;
  vec_t                                  acc;

  cpu_control cpu_control0 (
    .clk_100mhz, .rst_n, .start,
    .instr, .instr_valid,
    .data_done, .data_vec,
    .weight_done, .weight_vec,
    .heap_rd_done, .heap_wr_done, .heap_vec,
    .acc,
    .fetch_req, .pc,
    .data_rd_req, .data_addr,
    .weight_rd_req, .weight_addr,
    .heap_rd_req, .heap_wr_req, .heap_addr,
    .alu_go, .alu_op, .alu_operand,
    .busy, .done, .inference_valid, .inference_out
  );

  instruction_fetch instruction_fetch0 (
    .clk_100mhz, .rst_n,
    .op_load_we, .load_addr, .load_data,
    .fetch_req, .pc, .instr, .instr_valid
  );

  vector_reader #(.ADDRS(`TNN_DATA_ADDRS)) data_reader0 (
    .clk_100mhz, .rst_n,
    .load_we   (data_load_we),
    .load_addr, .load_data,
    .rd_req    (data_rd_req),
    .rd_addr   (data_addr),
    .rd_vec    (data_vec),
    .rd_done   (data_done)
  );

  vector_reader #(.ADDRS(`TNN_WEIGHT_ADDRS)) weight_reader0 (
    .clk_100mhz, .rst_n,
    .load_we   (weight_load_we),
    .load_addr, .load_data,
    .rd_req    (weight_rd_req),
    .rd_addr   (weight_addr),
    .rd_vec    (weight_vec),
    .rd_done   (weight_done)
  );

  heap_store heap_store0 (
    .clk_100mhz, .rst_n,
    .wr_req    (heap_wr_req),
    .rd_req    (heap_rd_req),
    .heap_addr,
    .wr_vec    (acc),           // Heap always stores the accumulator
    .rd_vec    (heap_vec),
    .wr_done   (heap_wr_done),
    .rd_done   (heap_rd_done)
  );

  vector_alu vector_alu0 (
    .clk_100mhz, .rst_n,
    .alu_go, .alu_op,
    .operand   (alu_operand),
    .acc
  );

endmodule

// ==== verilog/vector_alu.sv ====
`timescale 1ns/1ps
`include "tnn_macros.svh"

module vector_alu (
  input  logic              clk_100mhz,
  input  logic              rst_n,
  input  logic              alu_go,    // One-cycle command
  input  tnn_pkg::alu_op_e  alu_op,
  input  tnn_pkg::vec_t     operand,   // Data, heap entry or weight matrix
  output tnn_pkg::vec_t     acc
);
  import tnn_pkg::*;

  // Lane i = sum_j trit(i,j) * x_j, wraps mod 256
  function automatic vec_t matvec(input vec_t w, input vec_t x);
    vec_t                    y;
    logic [`TNN_LANE_W-1:0]  sum;
    logic [`TNN_LANE_W-1:0]  lane;
    logic [`TNN_TRIT_W-1:0]  trit;
    y = '0;
    for (int i = 0; i < `TNN_LANES; i++) begin
      sum = '0;
      for (int j = 0; j < `TNN_LANES; j++) begin
        trit = w[`TNN_TRIT_W*(`TNN_LANES*i+j) +: `TNN_TRIT_W];
        lane = x[`TNN_LANE_W*j +: `TNN_LANE_W];
        if (trit == 2'b01) begin
          sum = sum + lane;         // +1
        end else if (trit == 2'b11) begin
          sum = sum - lane;         // -1, 00 and 10 are zero
        end
      end
      y[`TNN_LANE_W*i +: `TNN_LANE_W] = sum;
    end
    return y;
  endfunction

  function automatic vec_t relu(input vec_t x);
    vec_t y;
    y = x;
    for (int i = 0; i < `TNN_LANES; i++) begin
      if (x[`TNN_LANE_W*i + `TNN_LANE_W-1]) begin
        y[`TNN_LANE_W*i +: `TNN_LANE_W] = '0;  // Negative lane
      end
    end
    return y;
  endfunction

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (alu_go) begin
      case (alu_op)
        ALU_LOAD:   acc <= operand;
        ALU_MATVEC: acc <= matvec(operand, acc);
        ALU_RELU:   acc <= relu(acc);
        default:    acc <= acc;
      endcase
    end
  end

endmodule

// ==== verilog/vector_reader.sv ====
`timescale 1ns/1ps
`include "tnn_macros.svh"

module vector_reader #(
  parameter int ADDRS = `TNN_DATA_ADDRS  // Entries, each two pieces
) (
  input  logic                         clk_100mhz,
  input  logic                         rst_n,
  input  logic                         load_we,
  input  logic [`TNN_LOAD_ADDR_W-1:0]  load_addr,  // Entry*2 + piece
  input  tnn_pkg::piece_t              load_data,
  input  logic                         rd_req,
  input  logic [$clog2(ADDRS)-1:0]     rd_addr,
  output tnn_pkg::vec_t                rd_vec,     // Holds until next request
  output logic                         rd_done     // 3 cycles after rd_req
);
  import tnn_pkg::*;

  localparam int AW = $clog2(ADDRS);
  localparam int PW = $clog2(ADDRS * `TNN_PIECES);

  piece_t          mem [ADDRS * `TNN_PIECES];
  logic [AW-1:0]   addr_q;
  logic [1:0]      step;      // 0 idle, 1 high piece, 2 join
  piece_t          piece_q;   // Synchronous read register
  piece_t          lo_q;      // Low half kept for the join

  always_ff @(posedge clk_100mhz) begin
    if (load_we) begin
      mem[load_addr[PW-1:0]] <= load_data;
    end
  end

  // One read port, piece 0 then piece 1
  always_ff @(posedge clk_100mhz) begin
    if (rd_req) begin
      piece_q <= mem[{rd_addr, 1'b0}];
      addr_q  <= rd_addr;
    end else if (step == 2'd1) begin
      lo_q    <= piece_q;
      piece_q <= mem[{addr_q, 1'b1}];
    end else if (step == 2'd2) begin
      rd_vec  <= {piece_q, lo_q};  // Piece 0 is the low half
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      step    <= 2'd0;
      rd_done <= 1'b0;
    end else begin
      rd_done <= (step == 2'd2);
      if (rd_req) begin
        step <= 2'd1;
      end else if (step != 2'd0) begin
        step <= (step == 2'd2) ? 2'd0 : step + 2'd1;
      end
    end
  end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/tnn_pkg.sv
verilog/instruction_fetch.sv
verilog/vector_reader.sv
verilog/heap_store.sv
verilog/vector_alu.sv
verilog/cpu_control.sv
verilog/tnn_top.sv
verification/tnn_tb.sv
